// File: hdl/color_select.sv
// Stage 1 of the colour path: colour and control registers plus object priority.
// Registers the winning colour code of each valid pixel onto the pixel bus.

`default_nettype none

module color_select (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wr_en,
  input  tia_video_pkg::reg_addr_e wr_addr,
  input  logic [7:0]               wr_data,
  input  logic                     pix_valid,
  input  logic                     blank,
  input  logic                     hit_p0,
  input  logic                     hit_p1,
  input  logic                     hit_pf,
  pixel_if.src                     pix
);
  import tia_color_pkg::*;
  import tia_video_pkg::*;

  color_code_t colup0;
  color_code_t colup1;
  color_code_t colupf;
  color_code_t colubk;
  logic        pf_above;
  logic        bw_mode;
  pix_src_e    win_src;
  color_code_t win_color;

  //////////////////////////////
  // Register file
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      colup0   <= '0;
      colup1   <= '0;
      colupf   <= '0;
      colubk   <= '0;
      pf_above <= 1'b0;
      bw_mode  <= 1'b0;
    end
    else if (wr_en)
    begin
      case (wr_addr)
        reg_colup0: colup0 <= color_code_t'(wr_data);
        reg_colup1: colup1 <= color_code_t'(wr_data);
        reg_colupf: colupf <= color_code_t'(wr_data);
        reg_colubk: colubk <= color_code_t'(wr_data);
        reg_ctrl:
        begin
          pf_above <= wr_data[CTRL_PF_ABOVE];
          bw_mode  <= wr_data[CTRL_BW_MODE];
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // Priority and pixel register
  //////////////////////////////

  // Players beat the playfield unless the playfield has been moved on top
  always_comb
  begin
    if (pf_above && hit_pf)
      win_src = src_pf;
    else if (hit_p0)
      win_src = src_p0;
    else if (hit_p1)
      win_src = src_p1;
    else if (hit_pf)
      win_src = src_pf;
    else
      win_src = src_bk;

    case (win_src)
      src_p0:  win_color = colup0;
      src_p1:  win_color = colup1;
      src_pf:  win_color = colupf;
      default: win_color = colubk;
    endcase

    // Monochrome keeps the brightness only
    if (bw_mode)
      win_color.hue = grey;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      pix.valid <= 1'b0;
    else
      pix.valid <= pix_valid;
  end

  always_ff @(posedge clk)
  begin
    if (pix_valid)
    begin
      pix.blank  <= blank;
      pix.color  <= win_color;
      pix.source <= win_src;
    end
  end

endmodule

`default_nettype wire

// File: hdl/ntsc_palette.sv
// Stage 2 of the colour path: NTSC colour code to RGB lookup with blanking.
// Takes the pixel bus from the selection stage and drives the RGB outputs.

`default_nettype none

`include "tia_video_consts.svh"

module ntsc_palette (
  input  logic                  clk,
  input  logic                  rst,
  pixel_if.dst                  pix,
  output logic [`TIA_RGB_W-1:0] rgb,
  output logic                  rgb_valid
);
  import tia_color_pkg::*;

  // Full 16 x 8 NTSC table, indexed by hue then luminance
  function automatic logic [`TIA_RGB_W-1:0] ntsc_rgb(input hue_e hue, input lum_t lum);
    case ({hue, lum})
      {grey, 3'd0}:         ntsc_rgb = 24'h000000;
      {grey, 3'd1}:         ntsc_rgb = 24'h404040;
      {grey, 3'd2}:         ntsc_rgb = 24'h6c6c6c;
      {grey, 3'd3}:         ntsc_rgb = 24'h909090;
      {grey, 3'd4}:         ntsc_rgb = 24'hb0b0b0;
      {grey, 3'd5}:         ntsc_rgb = 24'hc8c8c8;
      {grey, 3'd6}:         ntsc_rgb = 24'hdcdcdc;
      {grey, 3'd7}:         ntsc_rgb = 24'hececec;
      {gold, 3'd0}:         ntsc_rgb = 24'h444400;
      {gold, 3'd1}:         ntsc_rgb = 24'h646410;
      {gold, 3'd2}:         ntsc_rgb = 24'h848424;
      {gold, 3'd3}:         ntsc_rgb = 24'ha0a034;
      {gold, 3'd4}:         ntsc_rgb = 24'hb8b840;
      {gold, 3'd5}:         ntsc_rgb = 24'hd0d050;
      {gold, 3'd6}:         ntsc_rgb = 24'he8e85c;
      {gold, 3'd7}:         ntsc_rgb = 24'hfcfc68;
      {orange, 3'd0}:       ntsc_rgb = 24'h702800;
      {orange, 3'd1}:       ntsc_rgb = 24'h844414;
      {orange, 3'd2}:       ntsc_rgb = 24'h985c28;
      {orange, 3'd3}:       ntsc_rgb = 24'hac783c;
      {orange, 3'd4}:       ntsc_rgb = 24'hbc8c4c;
      {orange, 3'd5}:       ntsc_rgb = 24'hcca05c;
      {orange, 3'd6}:       ntsc_rgb = 24'hdcb468;
      {orange, 3'd7}:       ntsc_rgb = 24'hecc878;
      {red_orange, 3'd0}:   ntsc_rgb = 24'h841800;
      {red_orange, 3'd1}:   ntsc_rgb = 24'h983418;
      {red_orange, 3'd2}:   ntsc_rgb = 24'hac5030;
      {red_orange, 3'd3}:   ntsc_rgb = 24'hc06848;
      {red_orange, 3'd4}:   ntsc_rgb = 24'hd0805c;
      {red_orange, 3'd5}:   ntsc_rgb = 24'he09470;
      {red_orange, 3'd6}:   ntsc_rgb = 24'heca880;
      {red_orange, 3'd7}:   ntsc_rgb = 24'hfcbc94;
      {pink, 3'd0}:         ntsc_rgb = 24'h880000;
      {pink, 3'd1}:         ntsc_rgb = 24'h9c2020;
      {pink, 3'd2}:         ntsc_rgb = 24'hb03c3c;
      {pink, 3'd3}:         ntsc_rgb = 24'hc05858;
      {pink, 3'd4}:         ntsc_rgb = 24'hd07070;
      {pink, 3'd5}:         ntsc_rgb = 24'he08888;
      {pink, 3'd6}:         ntsc_rgb = 24'heca0a0;
      {pink, 3'd7}:         ntsc_rgb = 24'hfcb4b4;
      {purple, 3'd0}:       ntsc_rgb = 24'h78005c;
      {purple, 3'd1}:       ntsc_rgb = 24'h8c2074;
      {purple, 3'd2}:       ntsc_rgb = 24'ha03c88;
      {purple, 3'd3}:       ntsc_rgb = 24'hb0589c;
      {purple, 3'd4}:       ntsc_rgb = 24'hc070b0;
      {purple, 3'd5}:       ntsc_rgb = 24'hd084c0;
      {purple, 3'd6}:       ntsc_rgb = 24'hdc9cd0;
      {purple, 3'd7}:       ntsc_rgb = 24'hecb0e0;
      {purple_blue, 3'd0}:  ntsc_rgb = 24'h480078;
      {purple_blue, 3'd1}:  ntsc_rgb = 24'h602090;
      {purple_blue, 3'd2}:  ntsc_rgb = 24'h783ca4;
      {purple_blue, 3'd3}:  ntsc_rgb = 24'h8c58b8;
      {purple_blue, 3'd4}:  ntsc_rgb = 24'ha070cc;
      {purple_blue, 3'd5}:  ntsc_rgb = 24'hb484dc;
      {purple_blue, 3'd6}:  ntsc_rgb = 24'hc49cec;
      {purple_blue, 3'd7}:  ntsc_rgb = 24'hd4b0fc;
      {blue, 3'd0}:         ntsc_rgb = 24'h140084;
      {blue, 3'd1}:         ntsc_rgb = 24'h302098;
      {blue, 3'd2}:         ntsc_rgb = 24'h4c3cac;
      {blue, 3'd3}:         ntsc_rgb = 24'h6858c0;
      {blue, 3'd4}:         ntsc_rgb = 24'h7c70d0;
      {blue, 3'd5}:         ntsc_rgb = 24'h9488e0;
      {blue, 3'd6}:         ntsc_rgb = 24'ha8a0ec;
      {blue, 3'd7}:         ntsc_rgb = 24'hbcb4fc;
      {blue1, 3'd0}:        ntsc_rgb = 24'h000088;
      {blue1, 3'd1}:        ntsc_rgb = 24'h1c209c;
      {blue1, 3'd2}:        ntsc_rgb = 24'h3840b0;
      {blue1, 3'd3}:        ntsc_rgb = 24'h505cc0;
      {blue1, 3'd4}:        ntsc_rgb = 24'h6874d0;
      {blue1, 3'd5}:        ntsc_rgb = 24'h7c8ce0;
      {blue1, 3'd6}:        ntsc_rgb = 24'h90a4ec;
      {blue1, 3'd7}:        ntsc_rgb = 24'ha4b8fc;
      {light_blue, 3'd0}:   ntsc_rgb = 24'h00187c;
      {light_blue, 3'd1}:   ntsc_rgb = 24'h1c3890;
      {light_blue, 3'd2}:   ntsc_rgb = 24'h3854a8;
      {light_blue, 3'd3}:   ntsc_rgb = 24'h5070bc;
      {light_blue, 3'd4}:   ntsc_rgb = 24'h6888cc;
      {light_blue, 3'd5}:   ntsc_rgb = 24'h7c9cdc;
      {light_blue, 3'd6}:   ntsc_rgb = 24'h90b4ec;
      {light_blue, 3'd7}:   ntsc_rgb = 24'ha4c8fc;
      {turquoise, 3'd0}:    ntsc_rgb = 24'h002c5c;
      {turquoise, 3'd1}:    ntsc_rgb = 24'h1c4c78;
      {turquoise, 3'd2}:    ntsc_rgb = 24'h386890;
      {turquoise, 3'd3}:    ntsc_rgb = 24'h5084ac;
      {turquoise, 3'd4}:    ntsc_rgb = 24'h689cc0;
      {turquoise, 3'd5}:    ntsc_rgb = 24'h7cb4d4;
      {turquoise, 3'd6}:    ntsc_rgb = 24'h90cce8;
      {turquoise, 3'd7}:    ntsc_rgb = 24'ha4e0fc;
      {green_blue, 3'd0}:   ntsc_rgb = 24'h003c2c;
      {green_blue, 3'd1}:   ntsc_rgb = 24'h1c5c48;
      {green_blue, 3'd2}:   ntsc_rgb = 24'h387c64;
      {green_blue, 3'd3}:   ntsc_rgb = 24'h509c80;
      {green_blue, 3'd4}:   ntsc_rgb = 24'h68b494;
      {green_blue, 3'd5}:   ntsc_rgb = 24'h7cd0ac;
      {green_blue, 3'd6}:   ntsc_rgb = 24'h90e4c0;
      {green_blue, 3'd7}:   ntsc_rgb = 24'ha4fcd4;
      {green, 3'd0}:        ntsc_rgb = 24'h003c00;
      {green, 3'd1}:        ntsc_rgb = 24'h205c20;
      {green, 3'd2}:        ntsc_rgb = 24'h407c40;
      {green, 3'd3}:        ntsc_rgb = 24'h5c9c5c;
      {green, 3'd4}:        ntsc_rgb = 24'h74b474;
      {green, 3'd5}:        ntsc_rgb = 24'h8cd08c;
      {green, 3'd6}:        ntsc_rgb = 24'ha4e4a4;
      {green, 3'd7}:        ntsc_rgb = 24'hb8fcb8;
      {yellow_green, 3'd0}: ntsc_rgb = 24'h143800;
      {yellow_green, 3'd1}: ntsc_rgb = 24'h345c1c;
      {yellow_green, 3'd2}: ntsc_rgb = 24'h507c38;
      {yellow_green, 3'd3}: ntsc_rgb = 24'h6c9850;
      {yellow_green, 3'd4}: ntsc_rgb = 24'h84b468;
      {yellow_green, 3'd5}: ntsc_rgb = 24'h9ccc7c;
      {yellow_green, 3'd6}: ntsc_rgb = 24'hb4e490;
      {yellow_green, 3'd7}: ntsc_rgb = 24'hc8fca4;
      {orange_green, 3'd0}: ntsc_rgb = 24'h2c3000;
      {orange_green, 3'd1}: ntsc_rgb = 24'h4c501c;
      {orange_green, 3'd2}: ntsc_rgb = 24'h687034;
      {orange_green, 3'd3}: ntsc_rgb = 24'h848c4c;
      {orange_green, 3'd4}: ntsc_rgb = 24'h9ca864;
      {orange_green, 3'd5}: ntsc_rgb = 24'hb4c078;
      {orange_green, 3'd6}: ntsc_rgb = 24'hccd488;
      {orange_green, 3'd7}: ntsc_rgb = 24'he0ec9c;
      {light_green, 3'd0}:  ntsc_rgb = 24'h442800;
      {light_green, 3'd1}:  ntsc_rgb = 24'h644818;
      {light_green, 3'd2}:  ntsc_rgb = 24'h846830;
      {light_green, 3'd3}:  ntsc_rgb = 24'ha08444;
      {light_green, 3'd4}:  ntsc_rgb = 24'hb89c58;
      {light_green, 3'd5}:  ntsc_rgb = 24'hd0b46c;
      {light_green, 3'd6}:  ntsc_rgb = 24'he8cc7c;
      {light_green, 3'd7}:  ntsc_rgb = 24'hfce08c;
      default:              ntsc_rgb = '0;
    endcase
  endfunction

  // Output holds its last colour between valid pixels; blanked pixels are black
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rgb_valid <= 1'b0;
      rgb       <= '0;
    end
    else
    begin
      rgb_valid <= pix.valid;
      if (pix.valid)
        rgb <= pix.blank ? '0 : ntsc_rgb(pix.color.hue, pix.color.lum);
    end
  end

endmodule

`default_nettype wire

// File: hdl/pixel_if.sv
// Pixel bus from the priority selection stage to the palette stage.
// One selected pixel per cycle, no back-pressure.

`default_nettype none

interface pixel_if;
  import tia_color_pkg::*;
  import tia_video_pkg::*;

  logic        valid;
  logic        blank;
  color_code_t color;
  pix_src_e    source;

  modport src (output valid, output blank, output color, output source);

  modport dst (input valid, input blank, input color, input source);

endinterface

`default_nettype wire

// File: hdl/tia_color_pkg.sv
// Colour code types shared by the selection and palette stages.
// Hue enum, luminance type and the 8-bit colour register format.

`default_nettype none

`include "tia_video_consts.svh"

package tia_color_pkg;

  // Hue order matches the upper nibble of a TIA colour register
  typedef enum logic [$clog2(`TIA_HUE_COUNT)-1:0] {
    grey,
    gold,
    orange,
    red_orange,
    pink,
    purple,
    purple_blue,
    blue,
    blue1,
    light_blue,
    turquoise,
    green_blue,
    green,
    yellow_green,
    orange_green,
    light_green
  } hue_e;

  typedef logic [$clog2(`TIA_LUM_COUNT)-1:0] lum_t;

  // Bit 0 is not decoded by the hardware
  typedef struct packed {
    hue_e hue;
    lum_t lum;
    logic spare;
  } color_code_t;

endpackage

`default_nettype wire

// File: hdl/tia_video_pkg.sv
// Register map and pixel source types for the TIA video block.
// Used by the selection stage, the pixel bus and the testbench.

`default_nettype none

package tia_video_pkg;

  typedef enum logic [2:0] {
    reg_colup0,
    reg_colup1,
    reg_colupf,
    reg_colubk,
    reg_ctrl
  } reg_addr_e;

  // Bit positions inside the control register
  localparam int unsigned CTRL_PF_ABOVE = 0;
  localparam int unsigned CTRL_BW_MODE  = 1;

  typedef enum logic [1:0] {
    src_p0,
    src_p1,
    src_pf,
    src_bk
  } pix_src_e;

endpackage

`default_nettype wire

// File: hdl/tia_video_top.sv
// Top level of the TIA colour output path: register writes and pixels in, RGB out.
// Chains the priority selection stage and the NTSC palette stage.

`default_nettype none

module tia_video_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wr_en,
  input  tia_video_pkg::reg_addr_e wr_addr,
  input  logic [7:0]               wr_data,
  input  logic                     pix_valid,
  input  logic                     blank,
  input  logic                     hit_p0,
  input  logic                     hit_p1,
  input  logic                     hit_pf,
  output logic [23:0]              rgb,
  output logic                     rgb_valid
);

  pixel_if u_pix ();

  color_select u_select (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .pix_valid (pix_valid),
    .blank     (blank),
    .hit_p0    (hit_p0),
    .hit_p1    (hit_p1),
    .hit_pf    (hit_pf),
    .pix       (u_pix)
  );

  ntsc_palette u_palette (
    .clk       (clk),
    .rst       (rst),
    .pix       (u_pix),
    .rgb       (rgb),
    .rgb_valid (rgb_valid)
  );

endmodule

`default_nettype wire

// File: include/tia_video_consts.svh
// Sizing constants for the TIA colour output path.
// Included by the packages, the palette stage and the testbench.

`ifndef TIA_VIDEO_CONSTS_SVH
`define TIA_VIDEO_CONSTS_SVH

// Number of NTSC hues and luminance steps in a colour code
`define TIA_HUE_COUNT 16
`define TIA_LUM_COUNT 8

// Width of the packed 8-bit-per-channel RGB output
`define TIA_RGB_W 24

// Cycles from a pixel at the inputs to its RGB value at the outputs
`define TIA_PIPE_LAT 2

`endif

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator from the project root and runs it
cd "$(dirname "$0")" && \
  verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
    --top-module tia_video_tb -o tia_video_sim && \
  ./obj_dir/tia_video_sim || exit 1

// File: tb.f
+incdir+include
hdl/tia_color_pkg.sv
hdl/tia_video_pkg.sv
hdl/pixel_if.sv
hdl/color_select.sv
hdl/ntsc_palette.sv
hdl/tia_video_top.sv
tb/tia_video_assert.sv
tb/tia_video_tb.sv

// File: tb/tia_video_assert.sv
// Concurrent checks on the TIA video top level, attached with bind.
// Covers output latency, blanked output, pixel source and reset behaviour.

`default_nettype none

`include "tia_video_consts.svh"

module tia_video_assert (
  input logic                     clk,
  input logic                     rst,
  input logic                     pix_valid,
  input logic                     blank,
  input logic                     hit_p0,
  input logic                     hit_p1,
  input logic                     hit_pf,
  input logic                     src_valid,
  input tia_video_pkg::pix_src_e  source,
  input logic [`TIA_RGB_W-1:0]    rgb,
  input logic                     rgb_valid
);
  timeunit 1ns;
  timeprecision 1ps;
  import tia_video_pkg::*;

  a_latency: assert property (@(posedge clk) disable iff (rst)
    rgb_valid == $past(pix_valid, `TIA_PIPE_LAT))
    else $error("rgb_valid does not follow pix_valid by the pipeline latency");

  // A blanked pixel leaves the palette as black
  a_blank_black: assert property (@(posedge clk) disable iff (rst)
    (rgb_valid && $past(blank, `TIA_PIPE_LAT)) |-> (rgb == '0))
    else $error("Blanked pixel produced a non-zero rgb value");

  // The recorded source must be an object that covered the pixel
  a_source_hit: assert property (@(posedge clk) disable iff (rst)
    src_valid |-> ((source == src_p0) ? $past(hit_p0) :
                   (source == src_p1) ? $past(hit_p1) :
                   (source == src_pf) ? $past(hit_pf) :
                   !($past(hit_p0) || $past(hit_p1) || $past(hit_pf))))
    else $error("Pixel source does not match the objects that covered it");

  a_reset_quiet: assert property (@(posedge clk) $past(rst) |-> !rgb_valid)
    else $error("rgb_valid is high while reset is applied");

endmodule

bind tia_video_top tia_video_assert u_assert (
  .clk       (clk),
  .rst       (rst),
  .pix_valid (pix_valid),
  .blank     (blank),
  .hit_p0    (hit_p0),
  .hit_p1    (hit_p1),
  .hit_pf    (hit_pf),
  .src_valid (u_pix.valid),
  .source    (u_pix.source),
  .rgb       (rgb),
  .rgb_valid (rgb_valid)
);

`default_nettype wire

// File: tb/tia_video_tb.sv
// Directed testbench for the TIA colour output path.
// Drives register writes and pixels, then checks each RGB result two cycles later.

`default_nettype none

`include "tia_video_consts.svh"

module tia_video_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import tia_video_pkg::*;

  localparam int PRI_PIXELS = 24;
  localparam int PIXEL_COUNT = 1 + 10 + 2 * PRI_PIXELS + 2 + 5;

  // Colour codes with a known NTSC entry, {hue, lum, spare}
  localparam logic [7:0] GREY_L0 = 8'h00;
  localparam logic [7:0] GREY_L7 = 8'h0e;
  localparam logic [7:0] GOLD_L7 = 8'h1e;
  localparam logic [7:0] BLUE_L0 = 8'h70;
  localparam logic [7:0] LTGREEN_L4 = 8'hf8;
  localparam logic [7:0] KNOWN [5] = '{GREY_L0, GREY_L7, GOLD_L7, BLUE_L0, LTGREEN_L4};

  logic        clk;
  logic        rst;
  logic        wr_en;
  reg_addr_e   wr_addr;
  logic [7:0]  wr_data;
  logic        pix_valid;
  logic        blank;
  logic        hit_p0;
  logic        hit_p1;
  logic        hit_pf;
  logic [23:0] rgb;
  logic        rgb_valid;

  logic [7:0]               model_reg [8];
  logic                     pf_above_m;
  logic                     bw_mode_m;
  logic [23:0]              exp_q [$];
  logic [31:0]              lcg_state = 32'd60;
  logic [`TIA_PIPE_LAT-1:0] valid_hist;

  tia_video_top DUT (
    .clk(clk), .rst(rst), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .pix_valid(pix_valid), .blank(blank), .hit_p0(hit_p0), .hit_p1(hit_p1),
    .hit_pf(hit_pf), .rgb(rgb), .rgb_valid(rgb_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // Reporting and reference model
  //////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [23:0] got,
                             input logic [23:0] expected);
    if (got !== expected)
      abort_run($sformatf("Mismatch %s: got 0x%06h, expected 0x%06h", name, got, expected));
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // The spare bit is not part of the palette index
  function automatic logic [23:0] known_rgb(input logic [7:0] code);
    case (code & 8'hfe)
      GREY_L0:    return 24'h000000;
      GREY_L7:    return 24'hececec;
      GOLD_L7:    return 24'hfcfc68;
      BLUE_L0:    return 24'h140084;
      LTGREEN_L4: return 24'hb89c58;
      default:    return 'x;
    endcase
  endfunction

  // pix is {blank, hit_p0, hit_p1, hit_pf}
  function automatic logic [23:0] predict(input logic [3:0] pix);
    logic [7:0] code;
    if (pix[3])
      return '0;
    if (pix[0] && pf_above_m)
      code = model_reg[reg_colupf];
    else if (pix[2])
      code = model_reg[reg_colup0];
    else if (pix[1])
      code = model_reg[reg_colup1];
    else if (pix[0])
      code = model_reg[reg_colupf];
    else
      code = model_reg[reg_colubk];
    if (bw_mode_m)
      code[7:4] = 4'h0;
    return known_rgb(code);
  endfunction

  //////////////////////////////
  // Stimulus and output monitor
  //////////////////////////////

  task automatic drive(input logic w, input reg_addr_e a, input logic [7:0] d,
                       input logic v, input logic [3:0] pix);
    @(posedge clk);
    wr_en     <= w;
    wr_addr   <= a;
    wr_data   <= d;
    pix_valid <= v;
    blank     <= pix[3];
    hit_p0    <= pix[2];
    hit_p1    <= pix[1];
    hit_pf    <= pix[0];
    // A pixel in the write cycle still sees the old register value
    if (v)
      exp_q.push_back(predict(pix));
    if (w && a == reg_ctrl)
    begin
      pf_above_m = d[0];
      bw_mode_m  = d[1];
    end
    else if (w)
      model_reg[a] = d;
  endtask

  task automatic write_reg(input reg_addr_e a, input logic [7:0] d);
    drive(1'b1, a, d, 1'b0, 4'h0);
  endtask

  task automatic send_pixel(input logic [3:0] pix);
    drive(1'b0, reg_ctrl, 8'h00, 1'b1, pix);
  endtask

  task automatic drain();
    while (exp_q.size() != 0)
      drive(1'b0, reg_ctrl, 8'h00, 1'b0, 4'h0);
  endtask

  initial
  begin
    valid_hist = '0;
    forever
    begin
      @(negedge clk);
      if (!rst)
      begin
        check_value("rgb_valid", 24'(rgb_valid), 24'(valid_hist[`TIA_PIPE_LAT-1]));
        if (rgb_valid && exp_q.size() == 0)
          abort_run("rgb_valid pulsed with no pixel in flight");
        else if (rgb_valid)
          check_value("rgb", rgb, exp_q.pop_front());
      end
      valid_hist = {valid_hist[`TIA_PIPE_LAT-2:0], pix_valid};
    end
  end

  initial
  begin
    repeat (PIXEL_COUNT + 50) @(posedge clk);
    abort_run("Watchdog expired before the tests completed");
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset_latency();
    int pulses;
    int first_seen;
    @(negedge clk);
    check_value("rgb_valid", 24'(rgb_valid), 24'h0);
    check_value("rgb", rgb, 24'h0);
    pulses     = 0;
    first_seen = -1;
    send_pixel(4'b0100);
    // Sample k is taken after edge N+k, where edge N takes the pixel
    for (int k = 0; k < 2 * `TIA_PIPE_LAT; k++)
    begin
      drive(1'b0, reg_ctrl, 8'h00, 1'b0, 4'h0);
      @(negedge clk);
      if (rgb_valid)
      begin
        pulses++;
        if (first_seen < 0)
          first_seen = k;
      end
    end
    check_value("rgb_valid pulse count", 24'(pulses), 24'd1);
    check_value("rgb_valid latency", 24'(first_seen + 1), 24'(`TIA_PIPE_LAT));
  endtask

  task automatic test_palette();
    for (int i = 0; i < 5; i++)
      for (int s = 0; s < 2; s++)
      begin
        write_reg(reg_colubk, KNOWN[i] | 8'(s));
        send_pixel(4'b0000);
      end
    drain();
  endtask

  task automatic test_priority();
    logic [31:0] r;
    write_reg(reg_colup0, GOLD_L7);
    write_reg(reg_colup1, BLUE_L0);
    write_reg(reg_colupf, LTGREEN_L4);
    write_reg(reg_colubk, GREY_L7);
    // Second pass moves the playfield above the players
    for (int pass = 0; pass < 2; pass++)
    begin
      write_reg(reg_ctrl, 8'(pass));
      repeat (PRI_PIXELS)
      begin
        r = lcg_next();
        send_pixel({1'b0, r[18:16]});
      end
    end
    drain();
  endtask

  task automatic test_bw_mode();
    write_reg(reg_ctrl, 8'h02);
    send_pixel(4'b0100);
    send_pixel(4'b0110);
    drain();
    check_value("rgb red vs green", 24'(rgb[23:16]), 24'(rgb[15:8]));
    check_value("rgb green vs blue", 24'(rgb[15:8]), 24'(rgb[7:0]));
    write_reg(reg_ctrl, 8'h00);
  endtask

  task automatic test_blank_write();
    logic [31:0] r;
    write_reg(reg_colubk, BLUE_L0);
    repeat (3)
    begin
      r = lcg_next();
      send_pixel({1'b1, r[18:16]});
    end
    drive(1'b1, reg_colubk, GREY_L7, 1'b1, 4'b0000);
    send_pixel(4'b0000);
    drain();
  endtask

  initial
  begin
    rst        = 1'b1;
    wr_en      = 1'b0;
    wr_addr    = reg_colup0;
    wr_data    = 8'h00;
    pix_valid  = 1'b0;
    blank      = 1'b0;
    hit_p0     = 1'b0;
    hit_p1     = 1'b0;
    hit_pf     = 1'b0;
    pf_above_m = 1'b0;
    bw_mode_m  = 1'b0;
    foreach (model_reg[i])
      model_reg[i] = 8'h00;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_reset_latency();
    test_palette();
    test_priority();
    test_bw_mode();
    test_blank_write();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
